// File: hw/umesh_pkg.sv
`default_nettype none

package umesh_pkg;

    localparam int ROW        = 4;   // routers per column
    localparam int ROUTER_NUM = 16;  // 4x4 mesh

    typedef logic [3:0]            node_idx_t;  // router index
    typedef logic [ROUTER_NUM-1:0] dst_mask_t;  // bit n set -> router n is a destination

    // position of the source inside its quadrant, sets the sweep directions
    typedef enum logic [1:0] {
        Q_TR = 2'b00,  // top-down, right-left
        Q_TL = 2'b01,  // top-down, left-right
        Q_BL = 2'b10,  // bottom-up, left-right
        Q_BR = 2'b11   // bottom-up, right-left
    } quadrant_e;

    typedef enum logic [1:0] {
        UNI_CENTER = 2'd0,  // unicast toward the level-2 center
        MULT_COL   = 2'd1,  // multicast down the source column
        MULT_ROW   = 2'd2   // multicast along the row
    } route_state_e;

    typedef struct packed {
        dst_mask_t l1_dst;
        dst_mask_t l2_dst;
        dst_mask_t mult_dst;
        quadrant_e src_pos;
    } route_cfg_t;

    typedef struct packed {
        node_idx_t    next_pos;
        dst_mask_t    doc;       // outgoing destination mask
        route_state_e state;
    } route_res_t;

endpackage

`default_nettype wire

// File: hw/apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [7:0] {
        L1_DST   = 8'h00,
        L2_DST   = 8'h04,
        MULT_DST = 8'h08,
        SRC_POS  = 8'h0C,
        RESULT   = 8'h10,  // next_pos and state, read only
        DOC      = 8'h14   // read only
    } reg_addr_e;

endpackage

`default_nettype wire

// File: hw/umesh_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_cfg_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t     apb_rsp,
    output umesh_pkg::route_cfg_t route_cfg,
    input  umesh_pkg::route_res_t route_res
);

    apb_pkg::reg_addr_e addr;
    logic               access;     // second cycle of a transfer
    logic               addr_hit;   // address maps to a register
    logic               read_only;  // RESULT or DOC
    logic [31:0]        rd_data;

    assign addr   = apb_pkg::reg_addr_e'(apb_req.paddr);
    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        addr_hit  = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (addr)
            apb_pkg::L1_DST: begin
                rd_data = {16'h0, route_cfg.l1_dst};
            end
            apb_pkg::L2_DST: begin
                rd_data = {16'h0, route_cfg.l2_dst};
            end
            apb_pkg::MULT_DST: begin
                rd_data = {16'h0, route_cfg.mult_dst};
            end
            apb_pkg::SRC_POS: begin
                rd_data = {30'h0, route_cfg.src_pos};
            end
            apb_pkg::RESULT: begin
                read_only = 1'b1;
                rd_data   = {26'h0, route_res.state, route_res.next_pos};
            end
            apb_pkg::DOC: begin
                read_only = 1'b1;
                rd_data   = {16'h0, route_res.doc};
            end
            default: begin
                addr_hit = 1'b0;  // unmapped, reads zero
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            route_cfg <= '0;
        end else if (access && apb_req.pwrite) begin
            case (addr)
                apb_pkg::L1_DST:   route_cfg.l1_dst   <= apb_req.pwdata[15:0];
                apb_pkg::L2_DST:   route_cfg.l2_dst   <= apb_req.pwdata[15:0];
                apb_pkg::MULT_DST: route_cfg.mult_dst <= apb_req.pwdata[15:0];
                apb_pkg::SRC_POS: begin
                    route_cfg.src_pos <= umesh_pkg::quadrant_e'(apb_req.pwdata[1:0]);
                end
                default: begin
                    route_cfg <= route_cfg;  // result regs and holes are not writable
                end
            endcase
        end
    end

    // zero wait states, response valid in the access cycle
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!addr_hit || (apb_req.pwrite && read_only));

endmodule

`default_nettype wire

// File: hw/umesh_route_classify.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_route_classify #(
    parameter int MY_XPOS = 0,
    parameter int MY_YPOS = 0
) (
    input  umesh_pkg::dst_mask_t    l1_dst,
    input  umesh_pkg::dst_mask_t    l2_dst,
    output umesh_pkg::route_state_e state,
    output logic [4:0]              l2_count,
    output umesh_pkg::node_idx_t    l2_left,
    output umesh_pkg::node_idx_t    l2_right
);

    localparam umesh_pkg::node_idx_t SRC =
        umesh_pkg::node_idx_t'(MY_XPOS * umesh_pkg::ROW + MY_YPOS);
    localparam logic [4:0] NODES = 5'(umesh_pkg::ROUTER_NUM);

    logic [4:0] l1_count;

    // population counts and level-2 edges in one sweep
    always_comb begin
        l1_count = '0;
        l2_count = '0;
        l2_left  = '0;
        l2_right = '0;
        for (logic [4:0] i = 5'd0; i < NODES; i++) begin
            l1_count = l1_count + 5'(l1_dst[i[3:0]]);
            l2_count = l2_count + 5'(l2_dst[i[3:0]]);
            if (l2_dst[i[3:0]]) begin
                l2_left = i[3:0];  // upward scan, last hit is the highest
            end
            if (l2_dst[~i[3:0]]) begin
                l2_right = ~i[3:0];  // downward scan, last hit is the lowest
            end
        end
    end

    always_comb begin
        if (l2_count > 5'd1 || (l2_count == 5'd1 && l2_right != SRC)) begin
            state = umesh_pkg::UNI_CENTER;
        end else if (l2_count == 5'd1 && l1_count > 5'd1) begin
            state = umesh_pkg::MULT_COL;  // we are the only level-2 node
        end else begin
            state = umesh_pkg::MULT_ROW;
        end
    end

endmodule

`default_nettype wire

// File: hw/umesh_center_split.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_center_split #(
    parameter int MY_XPOS = 0,
    parameter int MY_YPOS = 0
) (
    input  umesh_pkg::dst_mask_t l2_dst,
    input  logic [4:0]           l2_count,
    input  umesh_pkg::node_idx_t l2_left,
    input  umesh_pkg::node_idx_t l2_right,
    output umesh_pkg::node_idx_t next_pos
);

    localparam umesh_pkg::node_idx_t SRC =
        umesh_pkg::node_idx_t'(MY_XPOS * umesh_pkg::ROW + MY_YPOS);
    localparam logic [4:0] TWICE_SRC = {SRC, 1'b0};
    localparam logic [4:0] NODES     = 5'(umesh_pkg::ROUTER_NUM);

    logic [4:0]           mid_sum;    // left + right, compared against 2*src
    logic [4:0]           half;
    logic                 send_low;   // source sits below the midpoint
    logic                 send_high;
    umesh_pkg::dst_mask_t low_cut;    // l2 with the lowest half cleared
    umesh_pkg::dst_mask_t high_cut;   // l2 with the highest half cleared
    umesh_pkg::dst_mask_t kept;
    umesh_pkg::node_idx_t kept_low;
    umesh_pkg::node_idx_t kept_high;

    assign mid_sum   = 5'(l2_left) + 5'(l2_right);
    assign half      = l2_count >> 1;
    assign send_low  = TWICE_SRC < mid_sum;
    assign send_high = TWICE_SRC > mid_sum;

    always_comb begin : halve
        logic [4:0] lo_left;
        logic [4:0] hi_left;
        low_cut  = l2_dst;
        high_cut = l2_dst;
        lo_left  = half;
        hi_left  = half;
        for (logic [4:0] i = 5'd0; i < NODES; i++) begin
            if (l2_dst[i[3:0]] && lo_left != 5'd0) begin
                low_cut[i[3:0]] = 1'b0;
                lo_left         = lo_left - 5'd1;
            end
            if (l2_dst[~i[3:0]] && hi_left != 5'd0) begin
                high_cut[~i[3:0]] = 1'b0;
                hi_left           = hi_left - 5'd1;
            end
        end
    end

    // on a tie we keep only the lower half
    always_comb begin
        if (send_low) begin
            kept = low_cut;
        end else if (send_high) begin
            kept = high_cut;
        end else begin
            kept = l2_dst ^ low_cut;
        end
    end

    always_comb begin
        kept_low  = '0;
        kept_high = '0;
        for (logic [4:0] i = 5'd0; i < NODES; i++) begin
            if (kept[i[3:0]]) begin
                kept_high = i[3:0];
            end
            if (kept[~i[3:0]]) begin
                kept_low = ~i[3:0];
            end
        end
    end

    assign next_pos = send_low ? kept_low : kept_high;

endmodule

`default_nettype wire

// File: hw/umesh_line_forward.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_line_forward #(
    parameter int MY_XPOS = 0,
    parameter int MY_YPOS = 0
) (
    input  umesh_pkg::dst_mask_t    l1_dst,
    input  umesh_pkg::dst_mask_t    mult_dst,
    input  umesh_pkg::quadrant_e    src_pos,
    input  umesh_pkg::route_state_e state,
    output umesh_pkg::node_idx_t    next_pos,
    output umesh_pkg::dst_mask_t    doc
);

    localparam umesh_pkg::node_idx_t SRC =
        umesh_pkg::node_idx_t'(MY_XPOS * umesh_pkg::ROW + MY_YPOS);
    localparam logic [4:0] NODES = 5'(umesh_pkg::ROUTER_NUM);
    localparam logic [4:0] STEP  = 5'(umesh_pkg::ROW);

    logic                 west;      // TR and BR sweep toward lower indices
    logic                 bottom;    // BL and BR search the column downward
    umesh_pkg::dst_mask_t col_doc;
    umesh_pkg::dst_mask_t row_doc;
    umesh_pkg::node_idx_t col_next;
    umesh_pkg::node_idx_t row_next;

    assign west   = (src_pos == umesh_pkg::Q_TR) || (src_pos == umesh_pkg::Q_BR);
    assign bottom = (src_pos == umesh_pkg::Q_BL) || (src_pos == umesh_pkg::Q_BR);

    always_comb begin : col_search
        logic [4:0] idx;
        logic       valid;
        logic       hit;
        col_next = SRC;
        hit      = 1'b0;
        for (logic [4:0] k = 5'd1; k < STEP; k++) begin
            idx   = bottom ? 5'(SRC) - k : 5'(SRC) + k;
            valid = bottom ? (k <= 5'(SRC)) : (idx < NODES);  // out of mesh reads zero
            if (!hit && valid && l1_dst[idx[3:0]]) begin
                col_next = idx[3:0];
                hit      = 1'b1;
            end
        end
    end

    // walk the source's row in steps of ROW, clearing and searching on the quadrant's side
    always_comb begin : row_search
        logic [4:0] off;
        logic [4:0] idx;
        logic       valid;
        logic       hit;
        col_doc      = mult_dst;
        row_doc      = mult_dst;
        row_doc[SRC] = 1'b0;
        row_next     = SRC;
        hit          = 1'b0;
        for (logic [4:0] k = 5'd0; k < NODES / STEP; k++) begin
            off   = k * STEP;
            idx   = west ? 5'(SRC) - off : 5'(SRC) + off;
            valid = west ? (off <= 5'(SRC)) : (idx < NODES);
            if (valid) begin
                col_doc[idx[3:0]] = 1'b0;
                if (!hit && row_doc[idx[3:0]]) begin  // row_doc[SRC] is already clear
                    row_next = idx[3:0];
                    hit      = 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (state)
            umesh_pkg::MULT_COL: begin
                next_pos = col_next;
                doc      = col_doc;
            end
            umesh_pkg::MULT_ROW: begin
                next_pos = row_next;
                doc      = row_doc;
            end
            default: begin
                next_pos = SRC;       // unicast hop comes from the split
                doc      = mult_dst;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/umesh_route_unit.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_route_unit #(
    parameter int MY_XPOS = 0,
    parameter int MY_YPOS = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  umesh_pkg::route_cfg_t route_cfg,
    output umesh_pkg::route_res_t route_res
);

    localparam umesh_pkg::node_idx_t SRC =
        umesh_pkg::node_idx_t'(MY_XPOS * umesh_pkg::ROW + MY_YPOS);

    umesh_pkg::route_state_e state;
    logic [4:0]              l2_count;
    umesh_pkg::node_idx_t    l2_left;
    umesh_pkg::node_idx_t    l2_right;
    umesh_pkg::node_idx_t    split_next;
    umesh_pkg::node_idx_t    line_next;
    umesh_pkg::dst_mask_t    line_doc;

    umesh_route_classify #(.MY_XPOS(MY_XPOS), .MY_YPOS(MY_YPOS)) route_classify_i (
        .l1_dst   (route_cfg.l1_dst),
        .l2_dst   (route_cfg.l2_dst),
        .state    (state),
        .l2_count (l2_count),
        .l2_left  (l2_left),
        .l2_right (l2_right)
    );

    umesh_center_split #(.MY_XPOS(MY_XPOS), .MY_YPOS(MY_YPOS)) center_split_i (
        .l2_dst   (route_cfg.l2_dst),
        .l2_count (l2_count),
        .l2_left  (l2_left),
        .l2_right (l2_right),
        .next_pos (split_next)
    );

    umesh_line_forward #(.MY_XPOS(MY_XPOS), .MY_YPOS(MY_YPOS)) line_forward_i (
        .l1_dst   (route_cfg.l1_dst),
        .mult_dst (route_cfg.mult_dst),
        .src_pos  (route_cfg.src_pos),
        .state    (state),
        .next_pos (line_next),
        .doc      (line_doc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            route_res.next_pos <= SRC;  // nowhere to go yet
            route_res.doc      <= '0;
            route_res.state    <= umesh_pkg::MULT_ROW;
        end else begin
            route_res.next_pos <= (state == umesh_pkg::UNI_CENTER) ? split_next : line_next;
            route_res.doc      <= line_doc;
            route_res.state    <= state;
        end
    end

endmodule

`default_nettype wire

// File: hw/umesh_router_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// one router's decision engine behind an APB slave port
module umesh_router_ctrl #(
    parameter int MY_XPOS = 0,  // column of this router, 0..3
    parameter int MY_YPOS = 0   // row of this router, 0..3
) (
    input  logic              clk,
    input  logic              rst,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp
);

    umesh_pkg::route_cfg_t route_cfg;  // masks and quadrant from the host
    umesh_pkg::route_res_t route_res;  // registered decision for readback

    umesh_cfg_regs cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .route_cfg (route_cfg),
        .route_res (route_res)
    );

    umesh_route_unit #(
        .MY_XPOS (MY_XPOS),
        .MY_YPOS (MY_YPOS)
    ) route_unit_i (
        .clk       (clk),
        .rst       (rst),
        .route_cfg (route_cfg),
        .route_res (route_res)
    );

endmodule

`default_nettype wire

// File: dv/umesh_ref_model.svh
`ifndef UMESH_REF_MODEL_SVH
`define UMESH_REF_MODEL_SVH

// positions outside the mesh read as zero
function automatic logic bit_at(umesh_pkg::dst_mask_t m, int idx);
    if (idx < 0 || idx >= umesh_pkg::ROUTER_NUM) return 1'b0;
    return m[idx[3:0]];
endfunction

function automatic umesh_pkg::dst_mask_t clear_at(umesh_pkg::dst_mask_t m, int idx);
    if (bit_at(m, idx)) m[idx[3:0]] = 1'b0;
    return m;
endfunction

function automatic umesh_pkg::route_state_e expected_state(umesh_pkg::dst_mask_t l1,
                                                           umesh_pkg::dst_mask_t l2, int s);
    int n1 = 0;
    int n2 = 0;
    int low = -1;
    for (int i = umesh_pkg::ROUTER_NUM - 1; i >= 0; i--) begin
        if (bit_at(l1, i)) n1++;
        if (bit_at(l2, i)) begin
            n2++;
            low = i;  // ends on the lowest set index
        end
    end
    if (n2 > 1 || (n2 == 1 && low != s)) return umesh_pkg::UNI_CENTER;
    if (n2 == 1 && n1 > 1) return umesh_pkg::MULT_COL;
    return umesh_pkg::MULT_ROW;
endfunction

// next hop after halving the level-2 set around the source
function automatic int split_next_hop(umesh_pkg::dst_mask_t l2, int s);
    int pos[$];
    int h;
    int sum;
    for (int i = 0; i < umesh_pkg::ROUTER_NUM; i++) begin
        if (bit_at(l2, i)) pos.push_back(i);
    end
    if (pos.size() == 0) return s;
    h   = pos.size() / 2;
    sum = pos[0] + pos[$];
    if (2 * s < sum) return pos[h];                   // h lowest dropped
    if (2 * s > sum) return pos[pos.size() - 1 - h];  // h highest dropped
    return (h == 0) ? pos[0] : pos[h - 1];            // only the h lowest kept
endfunction

function automatic umesh_pkg::route_res_t expected_route(umesh_pkg::route_cfg_t cfg, int s);
    umesh_pkg::route_res_t res;
    logic                  west;
    logic                  down;
    int                    idx;
    int                    hop;
    west      = cfg.src_pos inside {umesh_pkg::Q_TR, umesh_pkg::Q_BR};
    down      = cfg.src_pos inside {umesh_pkg::Q_BL, umesh_pkg::Q_BR};
    res.state = expected_state(cfg.l1_dst, cfg.l2_dst, s);
    res.doc   = cfg.mult_dst;
    hop       = s;
    if (res.state == umesh_pkg::UNI_CENTER) begin
        hop = split_next_hop(cfg.l2_dst, s);
    end else if (res.state == umesh_pkg::MULT_COL) begin
        for (int k = 0; k * umesh_pkg::ROW < umesh_pkg::ROUTER_NUM; k++) begin
            res.doc = clear_at(res.doc, west ? s - k * umesh_pkg::ROW : s + k * umesh_pkg::ROW);
        end
        for (int k = 1; k < umesh_pkg::ROW; k++) begin
            idx = down ? s - k : s + k;
            if (bit_at(cfg.l1_dst, idx)) begin
                hop = idx;
                break;
            end
        end
    end else begin
        res.doc = clear_at(cfg.mult_dst, s);
        for (int k = 1; k * umesh_pkg::ROW < umesh_pkg::ROUTER_NUM; k++) begin
            idx = west ? s - k * umesh_pkg::ROW : s + k * umesh_pkg::ROW;
            if (bit_at(res.doc, idx)) begin
                hop = idx;
                break;
            end
        end
    end
    res.next_pos = umesh_pkg::node_idx_t'(hop);
    return res;
endfunction

`endif

// File: dv/umesh_tb.sv
`timescale 1ns/10ps
`default_nettype none

module umesh_tb;

    localparam int MY_XPOS = 1;
    localparam int MY_YPOS = 2;
    localparam int SRC     = MY_XPOS * umesh_pkg::ROW + MY_YPOS;
    // about 700 transfers of 3 cycles each, rounded up with margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              rst;
    apb_pkg::apb_req_t apb_req;
    apb_pkg::apb_rsp_t apb_rsp;
    int                cycle_count;
    int                check_count;
    int                error_count;
    int                test_start_errors;

    `include "umesh_ref_model.svh"

    umesh_router_ctrl #(.MY_XPOS(MY_XPOS), .MY_YPOS(MY_YPOS)) umesh_router_ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;  // 4 ns period
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycle_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        assert (actual == expected) else begin
            $display("error: %0t %s expected 0x%08h actual 0x%08h", $time, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(string name);
        $display("test %s: %s, %0d errors", name,
                 (error_count == test_start_errors) ? "ok" : "failed",
                 error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    // setup cycle, then access until pready, sampled on the falling edge
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        apb_pkg::apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk);
        apb_req <= req;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        check_value("pready", 32'h1, 32'(apb_rsp.pready));  // no wait states
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data, logic expect_err);
        logic [31:0] ignored;
        logic        slverr;
        apb_transfer(1'b1, addr, data, ignored, slverr);
        check_value("pslverr", 32'(expect_err), 32'(slverr));
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic expect_err,
                            output logic [31:0] data);
        logic slverr;
        apb_transfer(1'b0, addr, 32'h0, data, slverr);
        check_value("pslverr", 32'(expect_err), 32'(slverr));
    endtask

    function automatic umesh_pkg::route_cfg_t make_cfg(logic [15:0] l1, logic [15:0] l2,
                                                       logic [15:0] mult,
                                                       umesh_pkg::quadrant_e quad);
        umesh_pkg::route_cfg_t cfg;
        cfg.l1_dst   = l1;
        cfg.l2_dst   = l2;
        cfg.mult_dst = mult;
        cfg.src_pos  = quad;
        return cfg;
    endfunction

    task automatic load_config(umesh_pkg::route_cfg_t cfg);
        apb_write(apb_pkg::L1_DST, 32'(cfg.l1_dst), 1'b0);
        apb_write(apb_pkg::L2_DST, 32'(cfg.l2_dst), 1'b0);
        apb_write(apb_pkg::MULT_DST, 32'(cfg.mult_dst), 1'b0);
        apb_write(apb_pkg::SRC_POS, 32'(cfg.src_pos), 1'b0);
    endtask

    task automatic check_route(umesh_pkg::route_cfg_t cfg);
        umesh_pkg::route_res_t exp;
        logic [31:0]           rd;
        exp = expected_route(cfg, SRC);
        load_config(cfg);
        apb_read(apb_pkg::RESULT, 1'b0, rd);
        check_value("next_pos", 32'(exp.next_pos), 32'(rd[3:0]));
        check_value("state", 32'(exp.state), 32'(rd[5:4]));
        check_value("result", {26'h0, exp.state, exp.next_pos}, rd);  // upper bits read zero
        apb_read(apb_pkg::DOC, 1'b0, rd);
        check_value("doc", 32'(exp.doc), rd);
    endtask

    initial begin : stimulus
        umesh_pkg::route_cfg_t cfg;
        logic [31:0]           rd;
        logic [15:0]           l2;
        rst               = 1'b1;
        apb_req           = '0;
        check_count       = 0;
        error_count       = 0;
        test_start_errors = 0;
        void'($urandom(32'hc967_7b92));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        apb_read(apb_pkg::RESULT, 1'b0, rd);
        check_value("next_pos", 32'(SRC), 32'(rd[3:0]));
        check_value("state", 32'(umesh_pkg::MULT_ROW), 32'(rd[5:4]));
        apb_read(apb_pkg::DOC, 1'b0, rd);
        check_value("doc", 32'h0, rd);
        finish_test("reset");

        apb_write(apb_pkg::L1_DST, 32'hffff_a5c3, 1'b0);  // upper half is dropped
        apb_read(apb_pkg::L1_DST, 1'b0, rd);
        check_value("l1_dst", 32'h0000_a5c3, rd);
        apb_write(apb_pkg::L2_DST, 32'h0000_0140, 1'b0);
        apb_read(apb_pkg::L2_DST, 1'b0, rd);
        check_value("l2_dst", 32'h0000_0140, rd);
        apb_write(apb_pkg::MULT_DST, 32'h1234_8001, 1'b0);
        apb_read(apb_pkg::MULT_DST, 1'b0, rd);
        check_value("mult_dst", 32'h0000_8001, rd);
        apb_write(apb_pkg::SRC_POS, 32'h0000_0006, 1'b0);
        apb_read(apb_pkg::SRC_POS, 1'b0, rd);
        check_value("src_pos", 32'h0000_0002, rd);
        apb_write(apb_pkg::RESULT, 32'hffff_ffff, 1'b1);
        apb_write(apb_pkg::DOC, 32'hffff_ffff, 1'b1);
        apb_read(8'h18, 1'b1, rd);
        apb_write(8'h1c, 32'h0000_0000, 1'b1);
        apb_read(apb_pkg::L1_DST, 1'b0, rd);  // rejected writes leave the config alone
        check_value("l1_dst", 32'h0000_a5c3, rd);
        apb_read(apb_pkg::L2_DST, 1'b0, rd);
        check_value("l2_dst", 32'h0000_0140, rd);
        apb_read(apb_pkg::MULT_DST, 1'b0, rd);
        check_value("mult_dst", 32'h0000_8001, rd);
        apb_read(apb_pkg::SRC_POS, 1'b0, rd);
        check_value("src_pos", 32'h0000_0002, rd);
        finish_test("registers");

        check_route(make_cfg(16'h0003, 16'h5500, 16'hf0f0, umesh_pkg::Q_TR));  // source below
        check_route(make_cfg(16'h0003, 16'h000f, 16'h0ff0, umesh_pkg::Q_BL));  // source above
        check_route(make_cfg(16'h0000, 16'h0404, 16'h1234, umesh_pkg::Q_TL));  // tie
        check_route(make_cfg(16'h0100, 16'h0150, 16'hffff, umesh_pkg::Q_BR));  // tie at source
        check_route(make_cfg(16'h0000, 16'h0200, 16'h8421, umesh_pkg::Q_TR));
        finish_test("unicast_center");

        check_route(make_cfg(16'h0108, 16'h0040, 16'hffff, umesh_pkg::Q_TR));
        check_route(make_cfg(16'h000a, 16'h0040, 16'hffff, umesh_pkg::Q_TL));  // empty search
        check_route(make_cfg(16'h1018, 16'h0040, 16'h5555, umesh_pkg::Q_BL));
        check_route(make_cfg(16'h0220, 16'h0040, 16'h4444, umesh_pkg::Q_BR));
        finish_test("column");

        check_route(make_cfg(16'h0001, 16'h0000, 16'h0444, umesh_pkg::Q_TR));
        check_route(make_cfg(16'h0001, 16'h0000, 16'h4040, umesh_pkg::Q_TL));
        check_route(make_cfg(16'h0001, 16'h0000, 16'h0440, umesh_pkg::Q_BL));
        check_route(make_cfg(16'h0001, 16'h0000, 16'h00c0, umesh_pkg::Q_BR));  // empty search
        finish_test("row");

        for (int n = 0; n < 60; n++) begin
            case ($urandom % 4)
                0: l2 = 16'h0000;
                1: l2 = 16'h0040;  // only the source, column or row forwarding
                2: l2 = 16'(1 << ($urandom % 16));
                default: l2 = 16'($urandom);
            endcase
            cfg = make_cfg(16'($urandom), l2, 16'($urandom),
                           umesh_pkg::quadrant_e'(2'($urandom)));
            check_route(cfg);
            apb_read(apb_pkg::L1_DST, 1'b0, rd);
            check_value("l1_dst", 32'(cfg.l1_dst), rd);
            apb_read(apb_pkg::L2_DST, 1'b0, rd);
            check_value("l2_dst", 32'(cfg.l2_dst), rd);
            apb_read(apb_pkg::MULT_DST, 1'b0, rd);
            check_value("mult_dst", 32'(cfg.mult_dst), rd);
            apb_read(apb_pkg::SRC_POS, 1'b0, rd);
            check_value("src_pos", 32'(cfg.src_pos), rd);
        end
        finish_test("random");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+dv
hw/umesh_pkg.sv
hw/apb_pkg.sv
hw/umesh_cfg_regs.sv
hw/umesh_route_classify.sv
hw/umesh_center_split.sv
hw/umesh_line_forward.sv
hw/umesh_route_unit.sv
hw/umesh_router_ctrl.sv
dv/umesh_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := umesh_tb
FILELIST := list.f
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
